/* mandel_pkg.sv */
package mandel_pkg;

	// Signed 4.23 fixed point
	typedef logic signed [26:0] fixed_t;

	// Packed as rrr_ggg_bb
	typedef logic [7:0] color_t;

	// Wide enough for 640 by 480
	localparam int MAX_ADDR_W = 19;

	// One frame buffer write
	typedef struct packed {
		logic                  we;
		logic [MAX_ADDR_W-1:0] addr;
		color_t                color;
	} pixel_write_t;

	// Point c of the recurrence
	typedef struct packed {
		fixed_t c_r;
		fixed_t c_i;
	} coord_t;

	// Video port, sync levels active low
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       blank_n;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} vga_out_t;

	typedef enum logic [1:0] {
		ITER_IDLE,
		ITER_CALC,
		ITER_DONE
	} iter_state_t;

	typedef enum logic {
		WALK_CALC,
		WALK_DONE
	} walk_state_t;

	// Shared by line and frame machines
	typedef enum logic [1:0] {
		SCAN_ACTIVE,
		SCAN_FRONT,
		SCAN_PULSE,
		SCAN_BACK
	} scan_state_t;

	// Threshold palette, first band reached wins
	function automatic color_t palette(input int unsigned count, input int unsigned limit);
		color_t c;
		if (count >= limit)
			c = 8'b000_000_00;
		else if (count >= (limit >> 1))
			c = 8'b011_001_00;
		else if (count >= (limit >> 2))
			c = 8'b011_001_00;
		else if (count >= (limit >> 3))
			c = 8'b101_010_01;
		else if (count >= (limit >> 4))
			c = 8'b011_001_01;
		else if (count >= (limit >> 5))
			c = 8'b001_001_01;
		else if (count >= (limit >> 6))
			c = 8'b011_010_10;
		else
			// Last bands all share one colour
			c = 8'b010_100_10;
		return c;
	endfunction

endpackage

/* escape_iterator.sv */
`timescale 1ns/1ns

module escape_iterator import mandel_pkg::*; #(
	parameter int ITER_MAX = 1000,
	localparam int CNT_W = $clog2(ITER_MAX) + 1
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_val,
	output logic             in_rdy,
	input  coord_t           c,
	output logic             out_val,
	input  logic             out_rdy,
	output logic [CNT_W-1:0] iter_count
);

	// Escape bounds in 4.23
	localparam fixed_t FOUR = 27'sh2000000;
	localparam fixed_t TWO = 27'sh1000000;

	iter_state_t state, state_next;
	coord_t c_reg;
	fixed_t zr, zi;
	fixed_t zr_sq, zi_sq, zr_zi;
	fixed_t zr_next, zi_next, mag_sq;
	logic escape;

	// 4.23 product keeps the sign bit and bits 48..23
	function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b);
		logic signed [53:0] full;
		full = a * b;
		return {full[53], full[48:23]};
	endfunction

	////////////////////////////////////////
	// One iteration per cycle
	////////////////////////////////////////
	assign zr_sq = fixed_mul(zr, zr);
	assign zi_sq = fixed_mul(zi, zi);
	assign zr_zi = fixed_mul(zr, zi);

	// z' = z^2 + c
	assign zr_next = zr_sq - zi_sq + c_reg.c_r;
	assign zi_next = (zr_zi <<< 1) + c_reg.c_i;
	// |z|^2 of the current z
	assign mag_sq = zr_sq + zi_sq;

	// Out of the circle, out of range, or out of iterations
	assign escape = (mag_sq > FOUR)
		|| (iter_count == CNT_W'(ITER_MAX - 1))
		|| (zr_next > TWO) || (zr_next < -TWO)
		|| (zi_next > TWO) || (zi_next < -TWO);

	////////////////////////////////////////
	// Control
	////////////////////////////////////////
	always_comb begin
		state_next = state;
		case (state)
			ITER_IDLE: begin
				if (in_val)
					state_next = ITER_CALC;
			end
			ITER_CALC: begin
				if (escape)
					state_next = ITER_DONE;
			end
			default: begin
				// Hold the count until the walker takes it
				if (out_rdy)
					state_next = ITER_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= ITER_IDLE;
		else
			state <= state_next;
	end

	// Load on accept, step while calculating
	always_ff @(posedge clk) begin
		if (state == ITER_IDLE && in_val) begin
			c_reg <= c;
			zr <= '0;
			zi <= '0;
			iter_count <= '0;
		end else if (state == ITER_CALC) begin
			zr <= zr_next;
			zi <= zi_next;
			iter_count <= iter_count + 1'b1;
		end
	end

	assign in_rdy = (state == ITER_IDLE);
	assign out_val = (state == ITER_DONE);

	// Never offering a result and taking a point at once
	assert property (@(posedge clk) disable iff (reset) !(out_val && in_rdy));

endmodule

/* pixel_walker.sv */
`timescale 1ns/1ns

module pixel_walker import mandel_pkg::*; #(
	parameter int     H_ACTIVE = 640,
	parameter int     V_ACTIVE = 480,
	parameter int     ITER_MAX = 1000,
	parameter fixed_t X_START = -27'sd16777216,
	parameter fixed_t Y_START = 27'sd8388608,
	parameter fixed_t STEP = 27'sd39000,
	parameter int     ADDR_W = 19
) (
	input  logic         clk,
	input  logic         reset,
	output pixel_write_t wr,
	output logic         done
);

	localparam int PIXELS = H_ACTIVE * V_ACTIVE;
	localparam int X_W = (H_ACTIVE > 1) ? $clog2(H_ACTIVE) : 1;
	localparam int CNT_W = $clog2(ITER_MAX) + 1;

	walk_state_t state;
	coord_t cur;
	logic [X_W-1:0] x_cnt;
	logic [ADDR_W-1:0] addr, wr_addr;
	color_t wr_color;
	logic we_q;
	logic in_val, in_rdy, out_val, out_rdy;
	logic [CNT_W-1:0] iter_count;
	logic take;

	escape_iterator #(
		.ITER_MAX(ITER_MAX)
	) u_iter (
		.clk       (clk),
		.reset     (reset),
		.in_val    (in_val),
		.in_rdy    (in_rdy),
		.c         (cur),
		.out_val   (out_val),
		.out_rdy   (out_rdy),
		.iter_count(iter_count)
	);

	// Result accepted, out_rdy follows next cycle
	assign take = (state == WALK_CALC) && out_val && !out_rdy;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= WALK_CALC;
			done <= 1'b0;
			in_val <= 1'b0;
			out_rdy <= 1'b0;
			we_q <= 1'b0;
			cur <= '{c_r: X_START, c_i: Y_START};
			x_cnt <= '0;
			addr <= '0;
		end else begin
			// One-cycle offer whenever the iterator sits idle
			in_val <= (state == WALK_CALC) && in_rdy && !in_val;
			out_rdy <= take;
			we_q <= take;
			// Rises once the last write is out
			if (state == WALK_DONE)
				done <= 1'b1;
			if (take) begin
				if (addr == ADDR_W'(PIXELS - 1))
					state <= WALK_DONE;
				addr <= addr + 1'b1;
				// Raster order, y falls per line
				if (x_cnt == X_W'(H_ACTIVE - 1)) begin
					x_cnt <= '0;
					cur.c_r <= X_START;
					cur.c_i <= cur.c_i - STEP;
				end else begin
					x_cnt <= x_cnt + 1'b1;
					cur.c_r <= cur.c_r + STEP;
				end
			end
		end
	end

	// Write payload
	always_ff @(posedge clk) begin
		if (take) begin
			wr_addr <= addr;
			wr_color <= palette(iter_count, ITER_MAX);
		end
	end

	assign wr = '{we: we_q, addr: MAX_ADDR_W'(wr_addr), color: wr_color};

	assert property (@(posedge clk) disable iff (reset) !(wr.we && done));
	// Last write lands inside the frame
	assert property (@(posedge clk) disable iff (reset)
		wr.we |-> wr.addr <= MAX_ADDR_W'(PIXELS - 1));

endmodule

/* frame_buffer.sv */
`timescale 1ns/1ns

module frame_buffer import mandel_pkg::*; #(
	parameter int ADDR_W = 19,
	parameter int DEPTH = 307200
) (
	input  logic              clk,
	input  pixel_write_t      wr,
	input  logic [ADDR_W-1:0] rd_addr,
	output color_t            rd_data
);

	// One colour per pixel
	color_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr.we)
			mem[wr.addr[ADDR_W-1:0]] <= wr.color;
		// Same-address collision reads the old value
		rd_data <= mem[rd_addr];
	end

endmodule

/* vga_timing.sv */
`timescale 1ns/1ns

module vga_timing import mandel_pkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_PULSE = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_PULSE = 2,
	parameter int V_BACK = 33,
	parameter int ADDR_W = 19
) (
	input  logic              clk,
	input  logic              reset,
	output logic [ADDR_W-1:0] rd_addr,
	input  color_t            rd_data,
	output vga_out_t          video
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_PULSE + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_PULSE + V_BACK;
	localparam int H_W = $clog2(H_TOTAL + 1);
	localparam int V_W = $clog2(V_TOTAL + 1);

	scan_state_t h_state, v_state;
	logic [H_W-1:0] h_cnt, h_len;
	logic [V_W-1:0] v_cnt, v_len;
	logic h_last, v_last, line_end;
	logic active, active_d, hsync_d, vsync_d;

	function automatic scan_state_t next_phase(input scan_state_t s);
		case (s)
			SCAN_ACTIVE: return SCAN_FRONT;
			SCAN_FRONT:  return SCAN_PULSE;
			SCAN_PULSE:  return SCAN_BACK;
			default:     return SCAN_ACTIVE;
		endcase
	endfunction

	////////////////////////////////////////
	// Horizontal, in pixels
	////////////////////////////////////////
	always_comb begin
		case (h_state)
			SCAN_ACTIVE: h_len = H_W'(H_ACTIVE);
			SCAN_FRONT:  h_len = H_W'(H_FRONT);
			SCAN_PULSE:  h_len = H_W'(H_PULSE);
			default:     h_len = H_W'(H_BACK);
		endcase
	end

	assign h_last = (h_cnt == h_len - 1'b1);
	// Last pixel of the back porch
	assign line_end = (h_state == SCAN_BACK) && h_last;

	always_ff @(posedge clk) begin
		if (reset) begin
			h_state <= SCAN_ACTIVE;
			h_cnt <= '0;
		end else if (h_last) begin
			h_state <= next_phase(h_state);
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Vertical, in lines
	////////////////////////////////////////
	always_comb begin
		case (v_state)
			SCAN_ACTIVE: v_len = V_W'(V_ACTIVE);
			SCAN_FRONT:  v_len = V_W'(V_FRONT);
			SCAN_PULSE:  v_len = V_W'(V_PULSE);
			default:     v_len = V_W'(V_BACK);
		endcase
	end

	assign v_last = (v_cnt == v_len - 1'b1);

	// Steps only on the line-end pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			v_state <= SCAN_ACTIVE;
			v_cnt <= '0;
		end else if (line_end) begin
			if (v_last) begin
				v_state <= next_phase(v_state);
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Read address and colour out
	////////////////////////////////////////
	assign active = (h_state == SCAN_ACTIVE) && (v_state == SCAN_ACTIVE);
	// In active video the counters are x and y
	assign rd_addr = active ? ADDR_W'(v_cnt) * ADDR_W'(H_ACTIVE) + ADDR_W'(h_cnt) : '0;

	// Stage 1 waits on the buffer, stage 2 drives the port
	always_ff @(posedge clk) begin
		if (reset) begin
			active_d <= 1'b0;
			hsync_d <= 1'b1;
			vsync_d <= 1'b1;
			video <= '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0, default: '0};
		end else begin
			active_d <= active;
			hsync_d <= (h_state != SCAN_PULSE);
			vsync_d <= (v_state != SCAN_PULSE);
			video.hsync <= hsync_d;
			video.vsync <= vsync_d;
			video.blank_n <= active_d;
			// Fields to the top of each byte
			video.red <= active_d ? {rd_data[7:5], 5'd0} : 8'd0;
			video.green <= active_d ? {rd_data[4:2], 5'd0} : 8'd0;
			video.blue <= active_d ? {rd_data[1:0], 6'd0} : 8'd0;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		video.blank_n |-> video.hsync && video.vsync);
	// hsync pulse width on the port
	assert property (@(posedge clk) disable iff (reset)
		$fell(video.hsync) |-> (!video.hsync) [*H_PULSE] ##1 video.hsync);

endmodule

/* mandel_display.sv */
`timescale 1ns/1ns

module mandel_display import mandel_pkg::*; #(
	parameter int     H_ACTIVE = 640,
	parameter int     H_FRONT = 16,
	parameter int     H_PULSE = 96,
	parameter int     H_BACK = 48,
	parameter int     V_ACTIVE = 480,
	parameter int     V_FRONT = 10,
	parameter int     V_PULSE = 2,
	parameter int     V_BACK = 33,
	parameter int     ITER_MAX = 1000,
	// -2.0, 1.0 and about 0.0046
	parameter fixed_t X_START = -27'sd16777216,
	parameter fixed_t Y_START = 27'sd8388608,
	parameter fixed_t STEP = 27'sd39000,
	parameter int     ADDR_W = 19
) (
	input  logic     clk,
	input  logic     reset,
	output vga_out_t video,
	output logic     done
);

	localparam int DEPTH = H_ACTIVE * V_ACTIVE;

	pixel_write_t wr;
	logic [ADDR_W-1:0] rd_addr;
	color_t rd_data;

	// Producer
	pixel_walker #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.ITER_MAX(ITER_MAX),
		.X_START (X_START),
		.Y_START (Y_START),
		.STEP    (STEP),
		.ADDR_W  (ADDR_W)
	) u_walker (
		.clk  (clk),
		.reset(reset),
		.wr   (wr),
		.done (done)
	);

	frame_buffer #(
		.ADDR_W(ADDR_W),
		.DEPTH (DEPTH)
	) u_fb (
		.clk    (clk),
		.wr     (wr),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	// Consumer, free running
	vga_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT (H_FRONT),
		.H_PULSE (H_PULSE),
		.H_BACK  (H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT (V_FRONT),
		.V_PULSE (V_PULSE),
		.V_BACK  (V_BACK),
		.ADDR_W  (ADDR_W)
	) u_vga (
		.clk    (clk),
		.reset  (reset),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.video  (video)
	);

endmodule

/* mandel_model.svh */
`ifndef MANDEL_MODEL_SVH
`define MANDEL_MODEL_SVH

// Start value for the reset time draw
localparam logic [31:0] LFSR_SEED = 32'h52de_42ea;

// Galois step, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic lsb;
	lsb = s[0];
	s = s >> 1;
	if (lsb)
		s = s ^ 32'h8020_0003;
	return s;
endfunction

// Same truncation as the hardware product
function automatic fixed_t mul_ref(input fixed_t a, input fixed_t b);
	logic signed [53:0] full;
	full = a * b;
	return {full[53], full[48:23]};
endfunction

// Escape count, the escaping step is counted too
function automatic int iter_ref(input fixed_t cr, input fixed_t ci, input int limit);
	fixed_t zr, zi, rr, ii, ri, nr, ni, mag;
	int n;
	logic esc;
	zr = '0;
	zi = '0;
	n = 0;
	esc = 1'b0;
	while (!esc) begin
		rr = mul_ref(zr, zr);
		ii = mul_ref(zi, zi);
		ri = mul_ref(zr, zi);
		nr = rr - ii + cr;
		ni = (ri <<< 1) + ci;
		mag = rr + ii;
		esc = (mag > 27'sh2000000) || (n == limit - 1)
			|| (nr > 27'sh1000000) || (nr < -27'sh1000000)
			|| (ni > 27'sh1000000) || (ni < -27'sh1000000);
		zr = nr;
		zi = ni;
		n++;
	end
	return n;
endfunction

// Band table, limit>>1 first
function automatic color_t palette_ref(input int count, input int limit);
	color_t band [8] = '{8'h64, 8'h64, 8'ha9, 8'h65, 8'h25, 8'h6a, 8'h52, 8'h52};
	int k;
	if (count >= limit)
		return 8'h00;
	for (k = 1; k <= 8; k++) begin
		if (count >= (limit >> k))
			return band[k-1];
	end
	return 8'h52;
endfunction

`endif

/* mandel_display_tb.sv */
`timescale 1ns/1ns

module mandel_display_tb import mandel_pkg::*; ();

	// Small frame of 23 pixels by 16 lines in total
	localparam int     H_ACTIVE = 16;
	localparam int     H_FRONT = 2;
	localparam int     H_PULSE = 3;
	localparam int     H_BACK = 2;
	localparam int     V_ACTIVE = 12;
	localparam int     V_FRONT = 1;
	localparam int     V_PULSE = 2;
	localparam int     V_BACK = 1;
	localparam int     ITER_MAX = 64;
	// -2.0, 1.0 and 0.1875 in 4.23
	localparam fixed_t X_START = -27'sd16777216;
	localparam fixed_t Y_START = 27'sd8388608;
	localparam fixed_t STEP = 27'sd1572864;
	localparam int     ADDR_W = 8;

	localparam int PIXELS = H_ACTIVE * V_ACTIVE;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_PULSE + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_PULSE + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int RESET_CYCLES = 16;
	// Worst case pixel budget plus three frames
	localparam int RUN_CYCLES = PIXELS * 16 * ITER_MAX + 3 * FRAME_CYCLES;
	// Two runs and two resets plus the longest reset delay
	localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 2 * RESET_CYCLES + 256 + FRAME_CYCLES;

	logic clk;
	logic reset;
	vga_out_t video;
	logic done;

	color_t expected [PIXELS];
	logic [31:0] lfsr;
	int reset_delay;

	// Monitor state
	int rst_cycles = 0;
	int h_low = 0;
	int v_low = 0;
	int blank_run = 0;
	logic h_prev = 1'b1;
	logic v_prev = 1'b1;
	logic b_prev = 1'b0;
	logic done_prev = 1'b0;

`include "mandel_model.svh"

	mandel_display #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT (H_FRONT),
		.H_PULSE (H_PULSE),
		.H_BACK  (H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT (V_FRONT),
		.V_PULSE (V_PULSE),
		.V_BACK  (V_BACK),
		.ITER_MAX(ITER_MAX),
		.X_START (X_START),
		.Y_START (Y_START),
		.STEP    (STEP),
		.ADDR_W  (ADDR_W)
	) UUT (
		.clk  (clk),
		.reset(reset),
		.video(video),
		.done (done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Failure and compare helpers
	////////////////////////////////////////
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR: %s is 0x%0h, expected 0x%0h", name, got, exp);
			fail_run("value mismatch, run stopped");
		end
	endtask

	// Expected colour of every pixel in raster order
	function automatic void build_reference();
		fixed_t cr, ci;
		for (int y = 0; y < V_ACTIVE; y++) begin
			for (int x = 0; x < H_ACTIVE; x++) begin
				cr = X_START + x * STEP;
				ci = Y_START - y * STEP;
				expected[y * H_ACTIVE + x] = palette_ref(iter_ref(cr, ci, ITER_MAX), ITER_MAX);
			end
		end
	endfunction

	// Reset held for RESET_CYCLES edges and changed 1 ns after the edge
	task automatic apply_reset();
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
	endtask

	task automatic wait_done();
		@(negedge clk);
		while (!done)
			@(negedge clk);
	endtask

	// Sync on the end of a vsync pulse and then take one frame of active pixels
	task automatic compare_frame(input string label);
		int p;
		p = 0;
		@(negedge clk);
		while (video.vsync)
			@(negedge clk);
		while (!video.vsync)
			@(negedge clk);
		while (p < PIXELS) begin
			if (video.blank_n) begin
				// Fields sit at the top of each byte
				check_value($sformatf("%s video.red pixel %0d", label, p),
					video.red, {expected[p][7:5], 5'd0});
				check_value($sformatf("%s video.green pixel %0d", label, p),
					video.green, {expected[p][4:2], 5'd0});
				check_value($sformatf("%s video.blue pixel %0d", label, p),
					video.blue, {expected[p][1:0], 6'd0});
				p++;
			end
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////
	// Sync and blanking monitor
	////////////////////////////////////////
	// Sampled mid-cycle on the falling edge
	always @(negedge clk) begin
		if (reset) begin
			rst_cycles = rst_cycles + 1;
			// DUT has seen reset for at least one edge
			if (rst_cycles >= 2) begin
				check_value("video", video, {1'b1, 1'b1, 1'b0, 24'h0});
				check_value("done", done, 1'b0);
			end
			h_prev = 1'b1;
			v_prev = 1'b1;
			b_prev = 1'b0;
			done_prev = 1'b0;
			h_low = 0;
			v_low = 0;
			blank_run = 0;
		end else begin
			rst_cycles = 0;
			if (video.blank_n && (!video.hsync || !video.vsync))
				fail_run("blank_n was high during a sync pulse");
			if (done_prev && !done)
				fail_run("done fell without a reset");
			// hsync pulse width in pixels
			if (!video.hsync)
				h_low++;
			else if (!h_prev) begin
				check_value("hsync low cycles", h_low, H_PULSE);
				h_low = 0;
			end
			// Active pixels per line
			if (video.blank_n)
				blank_run++;
			else if (b_prev) begin
				check_value("blank_n high cycles", blank_run, H_ACTIVE);
				blank_run = 0;
			end
			// vsync pulse width in whole lines
			if (!video.vsync)
				v_low++;
			else if (!v_prev) begin
				check_value("vsync low cycles", v_low, V_PULSE * H_TOTAL);
				v_low = 0;
			end
			h_prev = video.hsync;
			v_prev = video.vsync;
			b_prev = video.blank_n;
			done_prev = done;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		fail_run("timeout, done or a complete frame did not arrive in time");
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		reset = 1'b1;
		lfsr = LFSR_SEED;
		reset_delay = 0;
		build_reference();

		apply_reset();
		wait_done();
		compare_frame("first frame");
		// Image must stay the same
		compare_frame("second frame");

		// Second reset at a time drawn from the LFSR one bit per step
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			reset_delay = (reset_delay << 1) | lfsr[0];
		end
		repeat (reset_delay) @(posedge clk);
		apply_reset();
		wait_done();
		compare_frame("frame after second reset");

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* src.f */
+incdir+.
mandel_pkg.sv
escape_iterator.sv
pixel_walker.sv
frame_buffer.sv
vga_timing.sv
mandel_display.sv
mandel_display_tb.sv

/* Bender.yml */
package:
  name: mandel_display

sources:
  - files:
      - mandel_pkg.sv
      - escape_iterator.sv
      - pixel_walker.sv
      - frame_buffer.sv
      - vga_timing.sv
      - mandel_display.sv
  - target: test
    include_dirs:
      - .
    files:
      - mandel_display_tb.sv
